//--- verilog/hello_pkg.sv
package hello_pkg;

  // ----------------------------------------------------------
  // Bus word types
  // ----------------------------------------------------------
  typedef logic [31:0] data_t;
  typedef logic [31:0] addr_t;
  typedef logic [1:0]  resp_t;

  localparam resp_t RESP_OKAY = 2'b00;

  // ----------------------------------------------------------
  // Register map
  // ----------------------------------------------------------
  localparam addr_t HELLO_ADDR    = 32'h0000_0500;
  localparam addr_t VLED_ADDR     = 32'h0000_0504;
  localparam addr_t CNT_CTRL_ADDR = 32'h0000_0508;
  // Load value low half, watermark high half
  localparam addr_t CNT_CFG_ADDR  = 32'h0000_050C;
  localparam addr_t CNT_STAT_ADDR = 32'h0000_0510;

  // Read value for holes in the map
  localparam data_t UNIMPL_VALUE = 32'hDEAD_BEEF;

  // Counter control fields, bit 0 is enable
  typedef struct packed {
    logic [19:0] rsvd;
    logic [7:0]  tick_value;
    logic        oneshot;
    logic        clear;
    logic        load;
    logic        enable;
  } cnt_ctrl_fields_t;

  // Bus side sees the raw word, counter side the fields
  typedef union packed {
    data_t            raw;
    cnt_ctrl_fields_t fields;
  } cnt_ctrl_u;

  // Counter status word
  typedef struct packed {
    logic [5:0]  rsvd;
    logic        tick;
    logic        ge_watermark;
    logic [7:0]  tick_cnt;
    logic [15:0] count;
  } cnt_stat_t;

endpackage

//--- verilog/reg_access_if.sv
interface reg_access_if import hello_pkg::*; ();

  // ----------------------------------------------------------
  // Write side
  // ----------------------------------------------------------
  // One-cycle strobe, aligned with the W handshake
  logic  wr_en;
  // Address latched at the AW handshake
  addr_t wr_addr;
  data_t wr_data;

  // ----------------------------------------------------------
  // Read side
  // ----------------------------------------------------------
  // Held stable from AR acceptance until rdata is loaded
  addr_t rd_addr;
  // Combinational mux output from the register file
  data_t rd_data;

  // Bus control end
  modport ctrl (
    output wr_en,
    output wr_addr,
    output wr_data,
    output rd_addr,
    input  rd_data
  );

  // Register file end
  modport regs (
    input  wr_en,
    input  wr_addr,
    input  wr_data,
    input  rd_addr,
    output rd_data
  );

endinterface

//--- verilog/ocl_slave_ctrl.sv
module ocl_slave_ctrl import hello_pkg::*; (
  input  logic  clk_main_a0,
  input  logic  rst_main_n_sync,
  // Write address
  input  logic  awvalid,
  input  addr_t awaddr,
  output logic  awready,
  // Write data
  input  logic  wvalid,
  input  data_t wdata,
  output logic  wready,
  // Write response
  output logic  bvalid,
  output resp_t bresp,
  input  logic  bready,
  // Read address
  input  logic  arvalid,
  input  addr_t araddr,
  output logic  arready,
  // Read data
  output logic  rvalid,
  output data_t rdata,
  output resp_t rresp,
  input  logic  rready,
  reg_access_if.ctrl ra
);

  // ----------------------------------------------------------
  // Write channel
  // ----------------------------------------------------------
  logic  wr_active;
  addr_t wr_addr_q;
  logic  aw_hs;

  // No new address while a response is still pending
  assign awready = !wr_active && !bvalid;
  assign aw_hs   = awvalid && awready;
  assign wready  = wr_active && wvalid;

  // Active from AW acceptance until the data beat
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      wr_active <= 1'b0;
    end else if (aw_hs) begin
      wr_active <= 1'b1;
    end else if (wready) begin
      wr_active <= 1'b0;
    end
  end

  always_ff @(posedge clk_main_a0) begin
    if (aw_hs) begin
      wr_addr_q <= awaddr;
    end
  end

  // Response one cycle after the data beat
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      bvalid <= 1'b0;
    end else if (wready) begin
      bvalid <= 1'b1;
    end else if (bready) begin
      bvalid <= 1'b0;
    end
  end

  assign bresp = RESP_OKAY;

  // Register file write strobe
  assign ra.wr_en   = wready;
  assign ra.wr_addr = wr_addr_q;
  assign ra.wr_data = wdata;

  // ----------------------------------------------------------
  // Read channel
  // ----------------------------------------------------------
  logic [1:0] rd_pipe;
  addr_t      rd_addr_q;
  logic       ar_hs;

  // One read in flight, blocked under R back-pressure
  assign arready = !(|rd_pipe) && !rvalid;
  assign ar_hs   = arvalid && arready;

  // Two-cycle delay from AR acceptance to rvalid
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      rd_pipe <= 2'b00;
    end else begin
      rd_pipe <= {rd_pipe[0], ar_hs};
    end
  end

  // Capture only on an accepted request
  always_ff @(posedge clk_main_a0) begin
    if (ar_hs) begin
      rd_addr_q <= araddr;
    end
  end

  assign ra.rd_addr = rd_addr_q;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      rvalid <= 1'b0;
    end else if (rd_pipe[1]) begin
      rvalid <= 1'b1;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

  // Data held until the beat is taken
  always_ff @(posedge clk_main_a0) begin
    if (rd_pipe[1]) begin
      rdata <= ra.rd_data;
    end
  end

  assign rresp = RESP_OKAY;

  // B must not drop before the host takes it
  ap_bvalid_hold: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    (bvalid && !bready) |=> bvalid)
    else $error("bvalid dropped without bready");

  // R beat stays put while stalled
  ap_rdata_stable: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    (rvalid && !rready) |=> (rvalid && $stable(rdata)))
    else $error("rdata changed while rvalid waited");

endmodule

//--- verilog/hello_regs.sv
module hello_regs import hello_pkg::*; #(
  parameter int VLED_W = 16
) (
  input  logic              clk_main_a0,
  input  logic              rst_main_n_sync,
  reg_access_if.regs        ra,
  output logic [VLED_W-1:0] hello_low,
  input  logic [VLED_W-1:0] vled_word,
  output cnt_ctrl_u         cnt_ctrl,
  output logic [15:0]       cnt_load,
  output logic [15:0]       cnt_watermark,
  input  cnt_stat_t         cnt_stat
);

  data_t     hello_q;
  cnt_ctrl_u cnt_ctrl_q;
  data_t     cnt_cfg_q;
  data_t     hello_swapped;

  // ----------------------------------------------------------
  // Write decode
  // ----------------------------------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      hello_q        <= '0;
      cnt_ctrl_q.raw <= '0;
      cnt_cfg_q      <= '0;
    end else if (ra.wr_en) begin
      case (ra.wr_addr)
        HELLO_ADDR:    hello_q        <= ra.wr_data;
        CNT_CTRL_ADDR: cnt_ctrl_q.raw <= ra.wr_data;
        CNT_CFG_ADDR:  cnt_cfg_q      <= ra.wr_data;
        // Read-only and unmapped writes dropped
        default: ;
      endcase
    end
  end

  // LED shadow source
  assign hello_low = hello_q[VLED_W-1:0];

  // Counter controls
  assign cnt_ctrl      = cnt_ctrl_q;
  assign cnt_load      = cnt_cfg_q[15:0];
  assign cnt_watermark = cnt_cfg_q[31:16];

  // ----------------------------------------------------------
  // Read mux
  // ----------------------------------------------------------
  // Byte order reversed on readback
  assign hello_swapped = {<<8{hello_q}};

  always_comb begin
    case (ra.rd_addr)
      HELLO_ADDR:    ra.rd_data = hello_swapped;
      // Unmasked shadow, not the pin value
      VLED_ADDR:     ra.rd_data = data_t'(vled_word);
      CNT_CTRL_ADDR: ra.rd_data = cnt_ctrl_q.raw;
      CNT_CFG_ADDR:  ra.rd_data = cnt_cfg_q;
      CNT_STAT_ADDR: ra.rd_data = cnt_stat;
      default:       ra.rd_data = UNIMPL_VALUE;
    endcase
  end

  // Bus side needs a fresh AW handshake per beat
  ap_wr_en_single: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    ra.wr_en |=> !ra.wr_en)
    else $error("back-to-back register write strobes");

endmodule

//--- verilog/vled_shadow.sv
module vled_shadow #(
  parameter int VLED_W      = 16,
  parameter int SYNC_STAGES = 2
) (
  input  logic              clk_main_a0,
  input  logic              rst_main_n_sync,
  input  logic [VLED_W-1:0] hello_low,
  input  logic [VLED_W-1:0] vdip,
  output logic [VLED_W-1:0] vled_word,
  output logic [VLED_W-1:0] vled
);

  // ----------------------------------------------------------
  // DIP synchronizer
  // ----------------------------------------------------------
  // Stage 0 samples the pins, last stage feeds the mask
  logic [SYNC_STAGES-1:0][VLED_W-1:0] dip_sync;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      dip_sync <= '0;
    end else begin
      dip_sync[0] <= vdip;
      for (int i = 1; i < SYNC_STAGES; i++) begin
        dip_sync[i] <= dip_sync[i-1];
      end
    end
  end

  // ----------------------------------------------------------
  // LED shadow and output
  // ----------------------------------------------------------
  // One cycle behind the hello-world register
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      vled_word <= '0;
    end else begin
      vled_word <= hello_low;
    end
  end

  // Masked by the switches, registered toward the pins
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      vled <= '0;
    end else begin
      vled <= vled_word & dip_sync[SYNC_STAGES-1];
    end
  end

endmodule

//--- verilog/tick_counter.sv
module tick_counter import hello_pkg::*; (
  input  logic        clk_main_a0,
  input  logic        rst_main_n_sync,
  input  cnt_ctrl_u   cnt_ctrl,
  input  logic [15:0] cnt_load,
  input  logic [15:0] cnt_watermark,
  output cnt_stat_t   cnt_stat
);

  localparam logic [15:0] CNT_MAX = 16'hFFFF;

  cnt_ctrl_u   ctrl_q;
  logic [15:0] load_q;
  logic [15:0] wmark_q;
  logic [7:0]  tick_cnt;
  logic [15:0] count;
  logic        tick_q;
  logic        tick_hit;
  logic        hold_max;

  // ----------------------------------------------------------
  // Control flops
  // ----------------------------------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      ctrl_q.raw <= '0;
      load_q     <= '0;
      wmark_q    <= '0;
    end else begin
      ctrl_q  <= cnt_ctrl;
      load_q  <= cnt_load;
      wmark_q <= cnt_watermark;
    end
  end

  // Period end, tick_value 0 ticks every cycle
  assign tick_hit = ctrl_q.fields.enable && (tick_cnt >= ctrl_q.fields.tick_value);

  // One-shot stops at the top instead of wrapping
  assign hold_max = ctrl_q.fields.oneshot && (count == CNT_MAX);

  // ----------------------------------------------------------
  // Tick divider
  // ----------------------------------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync || ctrl_q.fields.clear) begin
      tick_cnt <= '0;
      tick_q   <= 1'b0;
    end else begin
      tick_q <= tick_hit;
      if (tick_hit) begin
        tick_cnt <= '0;
      end else if (ctrl_q.fields.enable) begin
        tick_cnt <= tick_cnt + 8'd1;
      end
    end
  end

  // Main counter, clear over load over count
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync || ctrl_q.fields.clear) begin
      count <= '0;
    end else if (ctrl_q.fields.load) begin
      count <= load_q;
    end else if (tick_hit && !hold_max) begin
      count <= count + 16'd1;
    end
  end

  always_comb begin
    cnt_stat              = '0;
    cnt_stat.count        = count;
    cnt_stat.tick_cnt     = tick_cnt;
    cnt_stat.ge_watermark = (count >= wmark_q);
    cnt_stat.tick         = tick_q;
  end

  ap_oneshot_no_wrap: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    (hold_max && !ctrl_q.fields.clear && !ctrl_q.fields.load) |=> (count == CNT_MAX))
    else $error("one-shot counter left its maximum");

endmodule

//--- verilog/hello_top.sv
module hello_top import hello_pkg::*; #(
  parameter int VLED_W = 16
) (
  input  logic              clk_main_a0,
  input  logic              rst_main_n_sync,
  input  logic              awvalid,
  input  addr_t             awaddr,
  output logic              awready,
  input  logic              wvalid,
  input  data_t             wdata,
  // Byte enables not supported, full-word writes only
  input  logic [3:0]        wstrb,
  output logic              wready,
  output logic              bvalid,
  output resp_t             bresp,
  input  logic              bready,
  input  logic              arvalid,
  input  addr_t             araddr,
  output logic              arready,
  output logic              rvalid,
  output data_t             rdata,
  output resp_t             rresp,
  input  logic              rready,
  input  logic [VLED_W-1:0] vdip,
  output logic [VLED_W-1:0] vled
);

  localparam int DIP_SYNC_STAGES = 2;

  logic [VLED_W-1:0] hello_low;
  logic [VLED_W-1:0] vled_word;
  cnt_ctrl_u         cnt_ctrl;
  logic [15:0]       cnt_load;
  logic [15:0]       cnt_watermark;
  cnt_stat_t         cnt_stat;

  // ----------------------------------------------------------
  // Bus control and register file
  // ----------------------------------------------------------
  reg_access_if u_ra ();

  ocl_slave_ctrl u_ocl_slave_ctrl (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .awvalid         (awvalid),
    .awaddr          (awaddr),
    .awready         (awready),
    .wvalid          (wvalid),
    .wdata           (wdata),
    .wready          (wready),
    .bvalid          (bvalid),
    .bresp           (bresp),
    .bready          (bready),
    .arvalid         (arvalid),
    .araddr          (araddr),
    .arready         (arready),
    .rvalid          (rvalid),
    .rdata           (rdata),
    .rresp           (rresp),
    .rready          (rready),
    .ra              (u_ra.ctrl)
  );

  hello_regs #(
    .VLED_W (VLED_W)
  ) u_hello_regs (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .ra              (u_ra.regs),
    .hello_low       (hello_low),
    .vled_word       (vled_word),
    .cnt_ctrl        (cnt_ctrl),
    .cnt_load        (cnt_load),
    .cnt_watermark   (cnt_watermark),
    .cnt_stat        (cnt_stat)
  );

  // ----------------------------------------------------------
  // LED path and counter
  // ----------------------------------------------------------
  vled_shadow #(
    .VLED_W      (VLED_W),
    .SYNC_STAGES (DIP_SYNC_STAGES)
  ) u_vled_shadow (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .hello_low       (hello_low),
    .vdip            (vdip),
    .vled_word       (vled_word),
    .vled            (vled)
  );

  tick_counter u_tick_counter (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .cnt_ctrl        (cnt_ctrl),
    .cnt_load        (cnt_load),
    .cnt_watermark   (cnt_watermark),
    .cnt_stat        (cnt_stat)
  );

endmodule

//--- tests/tb_hello_top.sv
module tb_hello_top import hello_pkg::*; ();

  localparam int    VLED_W         = 16;
  localparam string PATTERN_FILE   = "tests/hello_patterns.txt";
  localparam int    N_RANDOM       = 16;
  localparam int    CYCLES_PER_OP  = 20;
  localparam int    TIMEOUT_MARGIN = 200;

  logic              clk_main_a0;
  logic              rst_main_n_sync;
  logic              awvalid;
  addr_t             awaddr;
  logic              awready;
  logic              wvalid;
  data_t             wdata;
  logic [3:0]        wstrb;
  logic              wready;
  logic              bvalid;
  resp_t             bresp;
  logic              bready;
  logic              arvalid;
  addr_t             araddr;
  logic              arready;
  logic              rvalid;
  data_t             rdata;
  resp_t             rresp;
  logic              rready;
  logic [VLED_W-1:0] vdip;
  logic [VLED_W-1:0] vled;

  int          checks;
  int          data_errors;
  int          resp_errors;
  int          vled_errors;
  int          flag_errors;
  int          other_errors;
  int          cycle_count;
  int          cycle_limit = 0;
  logic [31:0] lcg_state;

  hello_top #(
    .VLED_W (VLED_W)
  ) u_hello_top (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .awvalid         (awvalid),
    .awaddr          (awaddr),
    .awready         (awready),
    .wvalid          (wvalid),
    .wdata           (wdata),
    .wstrb           (wstrb),
    .wready          (wready),
    .bvalid          (bvalid),
    .bresp           (bresp),
    .bready          (bready),
    .arvalid         (arvalid),
    .araddr          (araddr),
    .arready         (arready),
    .rvalid          (rvalid),
    .rdata           (rdata),
    .rresp           (rresp),
    .rready          (rready),
    .vdip            (vdip),
    .vled            (vled)
  );

  initial begin
    clk_main_a0 = 1'b0;
    forever #4 clk_main_a0 = ~clk_main_a0;
  end

  // Watchdog armed once the pattern length is known
  initial begin
    cycle_count = 0;
    wait (cycle_limit > 0);
    while (cycle_count < cycle_limit) begin
      @(posedge clk_main_a0);
      cycle_count++;
    end
    $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
    $display("Test FAILED");
    $finish;
  end

  // ----------------------------------------------------------
  // Reference rules and stimulus helpers
  // ----------------------------------------------------------
  // Hello readback moves byte 0 to the top
  function automatic data_t byte_swap(input data_t w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic check_data(input string what, input data_t got, input data_t exp);
    checks++;
    if (got !== exp) begin
      data_errors++;
      $display("[ERROR] %0t %s: got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_resp(input string what, input resp_t got, input resp_t exp);
    checks++;
    if (got !== exp) begin
      resp_errors++;
      $display("[ERROR] %0t %s: got %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_vled(input string what, input logic [VLED_W-1:0] got,
                            input logic [VLED_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      vled_errors++;
      $display("[ERROR] %0t %s: got %h, expected %h", $time, what, got, exp);
    end
  endtask

  // Single handshake bits
  task automatic check_flag(input string what, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      flag_errors++;
      $display("[ERROR] %0t %s: got %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(negedge clk_main_a0);
  endtask

  // Drives AW and W together and returns at the negedge that sees bvalid
  task automatic start_write(input addr_t addr, input data_t data);
    @(negedge clk_main_a0);
    awvalid = 1'b1;
    awaddr  = addr;
    wvalid  = 1'b1;
    wdata   = data;
    while (!awready) @(negedge clk_main_a0);
    // No data beat before the address is taken
    check_flag("wready before AW handshake", wready, 1'b0);
    @(negedge clk_main_a0);
    check_flag("wready after AW handshake", wready, 1'b1);
    awvalid = 1'b0;
    while (!bvalid) @(negedge clk_main_a0);
    check_flag("wready after the data beat", wready, 1'b0);
    wvalid = 1'b0;
  endtask

  task automatic bus_write(input addr_t addr, input data_t data);
    start_write(addr, data);
    check_resp($sformatf("write %h bresp", addr), bresp, RESP_OKAY);
  endtask

  // rready stays high, so rvalid lasts one cycle
  task automatic bus_read(input addr_t addr, output data_t data, output resp_t resp);
    @(negedge clk_main_a0);
    arvalid = 1'b1;
    araddr  = addr;
    while (!arready) @(negedge clk_main_a0);
    @(negedge clk_main_a0);
    arvalid = 1'b0;
    while (!rvalid) @(negedge clk_main_a0);
    data = rdata;
    resp = rresp;
  endtask

  task automatic read_expect(input addr_t addr, input data_t exp);
    data_t got;
    resp_t resp;
    bus_read(addr, got, resp);
    check_data($sformatf("read %h", addr), got, exp);
    check_resp($sformatf("read %h rresp", addr), resp, RESP_OKAY);
  endtask

  // ----------------------------------------------------------
  // Test sections
  // ----------------------------------------------------------
  task automatic check_reset_state();
    check_flag("awready after reset", awready, 1'b1);
    check_flag("arready after reset", arready, 1'b1);
    check_flag("bvalid after reset", bvalid, 1'b0);
    check_flag("rvalid after reset", rvalid, 1'b0);
    check_vled("vled after reset", vled, '0);
  endtask

  task automatic run_patterns(input int fd);
    string       line;
    string       op;
    int          n_fields;
    int          line_no;
    logic [31:0] arg;
    logic [31:0] val;
    line_no = 0;
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      line_no++;
      // Comment lines
      if (line.len() > 0 && line.substr(0, 0) == "#") continue;
      n_fields = $sscanf(line, "%s %h %h", op, arg, val);
      if (n_fields < 1) continue;
      if (n_fields != 3) begin
        other_errors++;
        $display("Pattern line %0d does not have three columns", line_no);
      end else if (op == "wr") begin
        bus_write(arg, val);
      end else if (op == "rd") begin
        read_expect(arg, val);
      end else if (op == "dip") begin
        @(negedge clk_main_a0);
        vdip = val[VLED_W-1:0];
      end else if (op == "led") begin
        @(negedge clk_main_a0);
        check_vled($sformatf("vled at pattern line %0d", line_no), vled, val[VLED_W-1:0]);
      end else if (op == "idle") begin
        idle_cycles(int'(arg));
      end else begin
        other_errors++;
        $display("Unknown operation %s on pattern line %0d", op, line_no);
      end
    end
  endtask

  task automatic check_random_hello();
    data_t word;
    for (int i = 0; i < N_RANDOM; i++) begin
      lcg_state = lcg_next(lcg_state);
      word = lcg_state;
      bus_write(HELLO_ADDR, word);
      read_expect(HELLO_ADDR, byte_swap(word));
    end
  endtask

  // Counter must have moved off its load value
  task automatic check_free_run();
    cnt_ctrl_u ctrl;
    cnt_stat_t stat;
    data_t     raw;
    resp_t     resp;
    bus_write(CNT_CFG_ADDR, 32'h0000_0100);
    ctrl.raw = '0;
    ctrl.fields.load = 1'b1;
    bus_write(CNT_CTRL_ADDR, ctrl.raw);
    idle_cycles(4);
    // Enable without one-shot and a tick every fourth cycle
    ctrl.raw = '0;
    ctrl.fields.enable     = 1'b1;
    ctrl.fields.tick_value = 8'd3;
    bus_write(CNT_CTRL_ADDR, ctrl.raw);
    idle_cycles(50);
    bus_read(CNT_STAT_ADDR, raw, resp);
    check_resp("free-run status rresp", resp, RESP_OKAY);
    stat = cnt_stat_t'(raw);
    checks++;
    if (stat.count == 16'h0100) begin
      data_errors++;
      $display("[ERROR] %0t free-running count stuck at load value %h", $time, stat.count);
    end
    bus_write(CNT_CTRL_ADDR, '0);
  endtask

  task automatic check_backpressure();
    @(negedge clk_main_a0);
    bready = 1'b0;
    start_write(HELLO_ADDR, 32'h0BAD_F00D);
    for (int i = 0; i < 4; i++) begin
      @(negedge clk_main_a0);
      check_flag("bvalid under B back-pressure", bvalid, 1'b1);
      check_flag("awready under B back-pressure", awready, 1'b0);
    end
    check_resp("held bresp", bresp, RESP_OKAY);
    bready = 1'b1;
    @(negedge clk_main_a0);
    check_flag("bvalid after bready", bvalid, 1'b0);
    check_flag("awready after bready", awready, 1'b1);
    read_expect(HELLO_ADDR, byte_swap(32'h0BAD_F00D));
  endtask

  task automatic report_and_finish();
    int total;
    total = data_errors + resp_errors + vled_errors + flag_errors + other_errors;
    $display("Checks %0d, errors: data %0d, resp %0d, vled %0d, flag %0d, other %0d",
             checks, data_errors, resp_errors, vled_errors, flag_errors, other_errors);
    if (total == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  endtask

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------
  initial begin
    int    fd;
    int    n_lines;
    string line;
    rst_main_n_sync = 1'b0;
    awvalid         = 1'b0;
    awaddr          = '0;
    wvalid          = 1'b0;
    wdata           = '0;
    wstrb           = 4'hF;
    bready          = 1'b1;
    arvalid         = 1'b0;
    araddr          = '0;
    rready          = 1'b1;
    // All switches on so only the reset can hold vled low
    vdip            = '1;
    lcg_state       = 32'h77a4_9ddd;
    checks          = 0;
    data_errors     = 0;
    resp_errors     = 0;
    vled_errors     = 0;
    flag_errors     = 0;
    other_errors    = 0;
    n_lines         = 0;
    fd = $fopen(PATTERN_FILE, "r");
    if (fd == 0) begin
      $display("Could not open the pattern file %s", PATTERN_FILE);
      $display("Test FAILED");
      $finish;
    end else begin
      // First pass only sizes the timeout
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        n_lines++;
      end
      $fclose(fd);
      cycle_limit = (n_lines + N_RANDOM) * CYCLES_PER_OP + TIMEOUT_MARGIN;
      repeat (3) @(negedge clk_main_a0);
      rst_main_n_sync = 1'b1;
      check_reset_state();
      fd = $fopen(PATTERN_FILE, "r");
      run_patterns(fd);
      $fclose(fd);
      check_random_hello();
      check_free_run();
      check_backpressure();
      report_and_finish();
    end
  end

endmodule

//--- sources.f
verilog/hello_pkg.sv
verilog/reg_access_if.sv
verilog/ocl_slave_ctrl.sv
verilog/hello_regs.sv
verilog/vled_shadow.sv
verilog/tick_counter.sv
verilog/hello_top.sv
tests/tb_hello_top.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the hello_top testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_hello_top -f sources.f
./obj_dir/Vtb_hello_top | tee sim.log

if grep -qx "Test OK" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed, see sim.log"
  exit 1
fi

//--- tests/hello_patterns.txt
# Columns: op, address or cycle count, data or expected value (all hex)
# wr addr data | rd addr expect | dip 0 pins | led 0 expect | idle cycles 0
rd   00000500 00000000
wr   00000500 11223344
rd   00000500 44332211
rd   00000504 00003344
dip  00000000 0000ff0f
idle 00000004 00000000
led  00000000 00003304
wr   00000500 a5a5c3c3
rd   00000500 c3c3a5a5
idle 00000004 00000000
led  00000000 0000c303
dip  00000000 0000ffff
idle 00000004 00000000
led  00000000 0000c3c3
rd   00000504 0000c3c3
rd   00000600 deadbeef
rd   00000514 deadbeef
rd   00000000 deadbeef
wr   0000050c 80001234
rd   0000050c 80001234
wr   00000508 00000002
idle 00000004 00000000
rd   00000510 00001234
rd   00000508 00000002
wr   0000050c 10001234
idle 00000004 00000000
rd   00000510 01001234
wr   00000508 00000004
idle 00000004 00000000
rd   00000510 00000000
wr   0000050c 0000fffe
wr   00000508 00000002
idle 00000004 00000000
wr   00000508 00000009
idle 00000010 00000000
rd   00000510 0300ffff
idle 00000010 00000000
rd   00000510 0300ffff
